/* branch_unit.f */
hw/cpu_pkg.sv
hw/branch_pkg.sv
hw/operand_capture.sv
hw/compare_station.sv
hw/branch_compare.sv
hw/branch_buffer.sv
hw/branch_ctrl.sv
hw/branch_unit.sv
tests/branch_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the branch unit testbench with Verilator, run it and look for the pass line
verilator --binary --timing --top-module branch_unit_tb -f branch_unit.f -o sim \
	&& ./obj_dir/sim | tee /dev/stderr | grep -qx "Test OK" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

/* tests/branch_unit_tb.sv */
module branch_unit_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import cpu_pkg::*;
	import branch_pkg::*;

	localparam int N_ENTRY = 4;
	localparam int N_BRANCH = 73; // Issued over all phases

	logic clk;
	logic arst_n;
	logic issue_valid;
	logic issue_ready;
	branch_op_t issue_op;
	cdb_t gpr_read [2];
	cdb_t fpr_read [2];
	cdb_t gpr_cdb;
	cdb_t fpr_cdb;
	logic prediction;
	logic [PATTERN_WIDTH-1:0] pattern_in;
	logic [ADDR_WIDTH-1:0] recovery_addr_in;
	logic commit_valid;
	logic commit_ready;
	logic failure;
	logic [PATTERN_WIDTH-1:0] pattern_out;
	logic [ADDR_WIDTH-1:0] recovery_addr_out;

	branch_entry_t sb [$]; // Expected commits, oldest first
	cdb_t gq [$];          // Broadcasts still owed on each bus
	cdb_t fq [$];
	logic [TAG_WIDTH-1:0] tag_ctr;
	logic exp_issue_ready;
	int issued;

	branch_unit #(.N_ENTRY(N_ENTRY)) dut_i (.*);

	function automatic branch_entry_t branch_expect(cmp_kind_t kind, logic [DATA_WIDTH-1:0] a,
			logic [DATA_WIDTH-1:0] b, logic pred, logic [PATTERN_WIDTH-1:0] pat,
			logic [ADDR_WIDTH-1:0] addr);
		logic taken;
		logic [DATA_WIDTH-2:0] ma;
		logic [DATA_WIDTH-2:0] mb;
		ma = a[DATA_WIDTH-2:0];
		mb = b[DATA_WIDTH-2:0];
		case (kind)
			CMP_FZ: taken = a[30:23] == '0;
			// Sign-magnitude order with both zeros equal
			CMP_FLE: taken = (ma == '0 && mb == '0) || (a[31] && !b[31])
				|| (!a[31] && !b[31] && ma <= mb) || (a[31] && b[31] && ma >= mb);
			CMP_EQ: taken = a == b;
			default: taken = $signed(a) <= $signed(b);
		endcase
		return '{failure: pred ^ taken, pattern: pat, recovery_addr: addr};
	endfunction

	task automatic stop_with(string line);
		$display("%s", line);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic check_entry(branch_entry_t got, branch_entry_t exp);
		if (got !== exp)
			stop_with($sformatf("Mismatch at %0t: commit got %p, expected %p", $time, got, exp));
	endtask

	task automatic expect_level(logic got, logic exp, string name);
		if (got !== exp)
			stop_with($sformatf("Mismatch at %0t: %s is %b, expected %b", $time, name, got, exp));
	endtask

	// Pops one owed broadcast in random order, or leaves the bus idle
	task automatic broadcast(inout cdb_t q [$], input bit en, output cdb_t bus);
		int idx;
		bus = '0;
		if (en && q.size() != 0 && $urandom % 2 == 1) begin
			idx = $urandom % q.size();
			bus = q[idx];
			q.delete(idx);
		end
	endtask

	task automatic step(input bit want, input int pend_pct, input int commit_pct, input bit bcast);
		branch_op_t op;
		cdb_t rd [2];
		logic [DATA_WIDTH-1:0] val [2];
		logic [DATA_WIDTH-1:0] b;
		logic is_int;
		bit pend;
		bit fire;
		@(posedge clk);
		#1;
		op.cmp_kind = cmp_kind_t'(2'($urandom));
		op.use_imm = 1'($urandom);
		op.imm = 16'(int'($urandom % 4) - 2);
		is_int = op.cmp_kind inside {CMP_EQ, CMP_LE};
		commit_valid = ($urandom % 100) < commit_pct;
		exp_issue_ready = sb.size() < N_ENTRY || (commit_valid && commit_ready);
		fire = want && exp_issue_ready;
		for (int j = 0; j < 2; j++) begin
			val[j] = ($urandom % 4 == 0) ? $urandom : $urandom % 2; // Mostly zeros and ones
			val[j][DATA_WIDTH-1] = 1'($urandom);
			pend = ($urandom % 100) < pend_pct
				&& !(j == 1 && (op.cmp_kind == CMP_FZ || (is_int && op.use_imm)));
			rd[j].valid = !pend;
			rd[j].tag = pend ? tag_ctr : TAG_WIDTH'($urandom);
			rd[j].data = pend ? $urandom : val[j];
			if (pend && fire) begin
				if (is_int)
					gq.push_back(cdb_t'{1'b1, tag_ctr, val[j]});
				else
					fq.push_back(cdb_t'{1'b1, tag_ctr, val[j]});
				tag_ctr++;
			end
		end
		b = (is_int && op.use_imm) ? {{(DATA_WIDTH-IMM_WIDTH){op.imm[IMM_WIDTH-1]}}, op.imm} : val[1];
		issue_valid = want;
		issue_op = op;
		prediction = 1'($urandom);
		pattern_in = PATTERN_WIDTH'($urandom);
		recovery_addr_in = ADDR_WIDTH'($urandom);
		gpr_read = '{default: '1}; // Wrong file shows up as all ones
		fpr_read = '{default: '1};
		if (is_int)
			gpr_read = rd;
		else
			fpr_read = rd;
		if (fire) begin
			sb.push_back(branch_expect(op.cmp_kind, val[0], b, prediction, pattern_in,
				recovery_addr_in));
			issued++;
		end
		broadcast(gq, bcast, gpr_cdb); // Same cycle as issue is possible
		broadcast(fq, bcast, fpr_cdb);
	endtask

	task automatic issue_batch(input int n, input int pend_pct, input int commit_pct);
		int target;
		target = issued + n;
		while (issued < target)
			step(1'b1, pend_pct, commit_pct, 1'b1);
	endtask

	task automatic drain();
		while (sb.size() != 0)
			step(1'b0, 0, 100, 1'b1);
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		#((20 * N_BRANCH + 200) * 10);
		stop_with("Commits stalled, the watchdog ran out before the last commit");
	end

	// Commit fires on the next rising edge
	always @(negedge clk) begin
		branch_entry_t got;
		if (arst_n) begin
			expect_level(issue_ready, exp_issue_ready, "issue_ready");
			if (commit_valid && commit_ready) begin
				if (sb.size() == 0)
					stop_with("Commit offered with no branch in flight");
				got = '{failure: failure, pattern: pattern_out, recovery_addr: recovery_addr_out};
				check_entry(got, sb.pop_front());
			end
		end
	end

	initial begin
		void'($urandom(61345));
		arst_n = 1'b0;
		issue_valid = 1'b0;
		issue_op = '0;
		gpr_read = '{default: '0};
		fpr_read = '{default: '0};
		gpr_cdb = '0;
		fpr_cdb = '0;
		prediction = 1'b0;
		pattern_in = '0;
		recovery_addr_in = '0;
		commit_valid = 1'b0;
		tag_ctr = '0;
		exp_issue_ready = 1'b1;
		issued = 0;
		repeat (2) @(posedge clk);
		#1 arst_n = 1'b1;
		expect_level(issue_ready, 1'b1, "issue_ready after reset");
		expect_level(commit_ready, 1'b0, "commit_ready after reset");
		issue_batch(12, 0, 100); // Operands valid at issue
		drain();
		// One branch held on a tag while both buses stay quiet
		step(1'b1, 100, 100, 1'b0);
		repeat (5) begin
			step(1'b0, 0, 100, 1'b0);
			expect_level(commit_ready, 1'b0, "commit_ready before broadcast");
		end
		drain();
		issue_batch(12, 60, 100);
		drain();
		repeat (N_ENTRY + 3)
			step(1'b1, 30, 0, 1'b1); // No commits, unit fills up
		expect_level(issue_ready, 1'b0, "issue_ready when full");
		issue_batch(N_ENTRY, 30, 100);
		drain();
		issue_batch(40, 50, 60);
		drain();
		$display("Test OK");
		$finish;
	end

endmodule

/* hw/branch_unit.sv */
module branch_unit #(
	parameter int N_ENTRY = 4
) (
	input logic clk,
	input logic arst_n,
	input logic issue_valid,
	output logic issue_ready,
	input branch_pkg::branch_op_t issue_op,
	input cpu_pkg::cdb_t gpr_read [2],
	input cpu_pkg::cdb_t fpr_read [2],
	input cpu_pkg::cdb_t gpr_cdb,
	input cpu_pkg::cdb_t fpr_cdb,
	input logic prediction,
	input logic [cpu_pkg::PATTERN_WIDTH-1:0] pattern_in,
	input logic [cpu_pkg::ADDR_WIDTH-1:0] recovery_addr_in,
	input logic commit_valid,
	output logic commit_ready,
	output logic failure,
	output logic [cpu_pkg::PATTERN_WIDTH-1:0] pattern_out,
	output logic [cpu_pkg::ADDR_WIDTH-1:0] recovery_addr_out
);
	import branch_pkg::*;

	logic issue_fire;
	logic commit_fire;
	logic dispatch_fire;
	logic [$clog2(N_ENTRY)-1:0] dispatch_index;
	logic head_ready;
	logic cmp_taken;
	cmp_entry_t new_entry;
	cmp_entry_t head;

	branch_ctrl #(.N_ENTRY(N_ENTRY)) u_ctrl (
		.clk(clk),
		.arst_n(arst_n),
		.issue_valid(issue_valid),
		.commit_valid(commit_valid),
		.head_ready(head_ready),
		.issue_ready(issue_ready),
		.commit_ready(commit_ready),
		.issue_fire(issue_fire),
		.commit_fire(commit_fire),
		.dispatch_fire(dispatch_fire),
		.dispatch_index(dispatch_index)
	);

	operand_capture u_capture (
		.issue_op(issue_op),
		.gpr_read(gpr_read),
		.fpr_read(fpr_read),
		.gpr_cdb(gpr_cdb),
		.fpr_cdb(fpr_cdb),
		.new_entry(new_entry)
	);

	compare_station #(.N_ENTRY(N_ENTRY)) u_station (
		.clk(clk),
		.arst_n(arst_n),
		.issue_fire(issue_fire),
		.dispatch_fire(dispatch_fire),
		.new_entry(new_entry),
		.gpr_cdb(gpr_cdb),
		.fpr_cdb(fpr_cdb),
		.head(head),
		.head_ready(head_ready)
	);

	branch_compare u_compare (
		.head(head),
		.cmp_taken(cmp_taken)
	);

	branch_buffer #(.N_ENTRY(N_ENTRY)) u_buffer (
		.clk(clk),
		.arst_n(arst_n),
		.issue_fire(issue_fire),
		.commit_fire(commit_fire),
		.dispatch_fire(dispatch_fire),
		.dispatch_index(dispatch_index),
		.cmp_taken(cmp_taken),
		.prediction(prediction),
		.pattern_in(pattern_in),
		.recovery_addr_in(recovery_addr_in),
		.failure(failure),
		.pattern_out(pattern_out),
		.recovery_addr_out(recovery_addr_out)
	);

endmodule

/* hw/branch_ctrl.sv */
module branch_ctrl #(
	parameter int N_ENTRY = 4
) (
	input logic clk,
	input logic arst_n,
	input logic issue_valid,
	input logic commit_valid,
	input logic head_ready,
	output logic issue_ready,
	output logic commit_ready,
	output logic issue_fire,
	output logic commit_fire,
	output logic dispatch_fire,
	output logic [$clog2(N_ENTRY)-1:0] dispatch_index
);
	localparam int CW = $clog2(N_ENTRY) + 1;
	localparam int IW = $clog2(N_ENTRY);

	logic [CW-1:0] cmp_count; // Unresolved branches
	logic [CW-1:0] buf_count; // Branches in flight

	// Head branch is resolved when the buffer holds more than the station
	assign commit_ready = buf_count > cmp_count;
	assign commit_fire = commit_valid && commit_ready;

	assign issue_ready = buf_count < CW'(N_ENTRY) || commit_fire;
	assign issue_fire = issue_valid && issue_ready;

	assign dispatch_fire = head_ready;
	// Resolved entries sit ahead of the head compare's slot
	assign dispatch_index = IW'(buf_count - cmp_count - CW'(commit_fire));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cmp_count <= '0;
			buf_count <= '0;
		end else begin
			cmp_count <= cmp_count - CW'(dispatch_fire) + CW'(issue_fire);
			buf_count <= buf_count - CW'(commit_fire) + CW'(issue_fire);
		end
	end

endmodule

/* hw/branch_buffer.sv */
module branch_buffer #(
	parameter int N_ENTRY = 4
) (
	input logic clk,
	input logic arst_n,
	input logic issue_fire,
	input logic commit_fire,
	input logic dispatch_fire,
	input logic [$clog2(N_ENTRY)-1:0] dispatch_index,
	input logic cmp_taken,
	input logic prediction,
	input logic [cpu_pkg::PATTERN_WIDTH-1:0] pattern_in,
	input logic [cpu_pkg::ADDR_WIDTH-1:0] recovery_addr_in,
	output logic failure,
	output logic [cpu_pkg::PATTERN_WIDTH-1:0] pattern_out,
	output logic [cpu_pkg::ADDR_WIDTH-1:0] recovery_addr_out
);
	import branch_pkg::*;

	localparam int CW = $clog2(N_ENTRY) + 1;
	localparam int IW = $clog2(N_ENTRY);

	logic [CW-1:0] count;
	logic [CW-1:0] kept;
	branch_entry_t fresh;
	branch_entry_t q [N_ENTRY];
	branch_entry_t shifted [N_ENTRY];
	branch_entry_t moved [N_ENTRY];

	assign fresh = '{failure: prediction, pattern: pattern_in, recovery_addr: recovery_addr_in};

	for (genvar i = 0; i < N_ENTRY; i++) begin : g_shift
		if (i == N_ENTRY - 1) begin : g_last
			assign shifted[i] = q[i];
		end else begin : g_mid
			assign shifted[i] = q[i+1];
		end
	end

	assign kept = count - CW'(commit_fire);

	always_comb begin
		for (int i = 0; i < N_ENTRY; i++) begin
			moved[i] = (i < int'(kept)) ? (commit_fire ? shifted[i] : q[i]) : fresh;
			// A taken compare inverts the stored prediction
			moved[i].failure = moved[i].failure
				^ (dispatch_fire && cmp_taken && dispatch_index == IW'(i));
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			count <= '0;
		end else begin
			count <= kept + CW'(issue_fire);
		end
	end

	always_ff @(posedge clk) begin
		q <= moved;
	end

	assign failure = q[0].failure; // Meaningful once resolved
	assign pattern_out = q[0].pattern;
	assign recovery_addr_out = q[0].recovery_addr;

endmodule

/* hw/branch_compare.sv */
module branch_compare (
	input branch_pkg::cmp_entry_t head,
	output logic cmp_taken
);
	import cpu_pkg::*;
	import branch_pkg::*;

	localparam int SIGN = DATA_WIDTH - 1;

	logic [DATA_WIDTH-1:0] a;
	logic [DATA_WIDTH-1:0] b;
	logic both_zero;
	logic fle;

	assign a = head.opd[0].data;
	assign b = head.opd[1].data;

	// Sign-magnitude order, +0 equals -0
	assign both_zero = a[SIGN-1:0] == '0 && b[SIGN-1:0] == '0;

	always_comb begin
		case ({a[SIGN], b[SIGN]})
			2'b00: fle = a[SIGN-1:0] <= b[SIGN-1:0];
			2'b11: fle = a[SIGN-1:0] >= b[SIGN-1:0];
			2'b10: fle = 1'b1;
			default: fle = both_zero;
		endcase
	end

	always_comb begin
		unique case (head.cmp_kind)
			CMP_FZ: cmp_taken = a[30:23] == '0; // Exponent field
			CMP_FLE: cmp_taken = fle;
			CMP_EQ: cmp_taken = a == b;
			default: cmp_taken = $signed(a) <= $signed(b);
		endcase
	end

endmodule

/* hw/compare_station.sv */
module compare_station #(
	parameter int N_ENTRY = 4
) (
	input logic clk,
	input logic arst_n,
	input logic issue_fire,
	input logic dispatch_fire,
	input branch_pkg::cmp_entry_t new_entry,
	input cpu_pkg::cdb_t gpr_cdb,
	input cpu_pkg::cdb_t fpr_cdb,
	output branch_pkg::cmp_entry_t head,
	output logic head_ready
);
	import cpu_pkg::*;
	import branch_pkg::*;

	localparam int CW = $clog2(N_ENTRY) + 1;

	logic [CW-1:0] count;
	logic [CW-1:0] kept;     // Entries that stay after a dispatch
	cmp_entry_t q [N_ENTRY];
	cmp_entry_t snooped [N_ENTRY];
	cmp_entry_t shifted [N_ENTRY];

	for (genvar i = 0; i < N_ENTRY; i++) begin : g_entry
		cdb_t bus;
		cmp_entry_t upd;

		assign bus = is_int_kind(q[i].cmp_kind) ? gpr_cdb : fpr_cdb;

		always_comb begin
			upd = q[i];
			for (int j = 0; j < 2; j++) begin
				if (!q[i].opd[j].valid && tag_match(bus, q[i].opd[j].tag)) begin
					upd.opd[j].valid = 1'b1;
					upd.opd[j].data = bus.data;
				end
			end
		end

		assign snooped[i] = upd;

		if (i == N_ENTRY - 1) begin : g_last
			assign shifted[i] = upd;
		end else begin : g_mid
			assign shifted[i] = snooped[i+1];
		end
	end

	assign kept = count - CW'(dispatch_fire);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			count <= '0;
		end else begin
			count <= kept + CW'(issue_fire);
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < N_ENTRY; i++) begin
			if (i < int'(kept)) begin
				q[i] <= dispatch_fire ? shifted[i] : snooped[i];
			end else begin
				q[i] <= new_entry; // Free slots load the incoming compare
			end
		end
	end

	assign head = q[0];
	// FZ reads operand 0 only
	assign head_ready = count != '0 && q[0].opd[0].valid
		&& (q[0].cmp_kind == CMP_FZ || q[0].opd[1].valid);

endmodule

/* hw/operand_capture.sv */
module operand_capture (
	input branch_pkg::branch_op_t issue_op,
	input cpu_pkg::cdb_t gpr_read [2],
	input cpu_pkg::cdb_t fpr_read [2],
	input cpu_pkg::cdb_t gpr_cdb,
	input cpu_pkg::cdb_t fpr_cdb,
	output branch_pkg::cmp_entry_t new_entry
);
	import cpu_pkg::*;
	import branch_pkg::*;

	logic int_kind;
	cdb_t bus;
	cdb_t rd;

	assign int_kind = is_int_kind(issue_op.cmp_kind);
	assign bus = int_kind ? gpr_cdb : fpr_cdb;

	always_comb begin
		new_entry.cmp_kind = issue_op.cmp_kind;
		rd = '0;
		for (int j = 0; j < 2; j++) begin
			rd = int_kind ? gpr_read[j] : fpr_read[j];
			new_entry.opd[j] = rd;
			// Producer broadcasts in the issue cycle itself
			if (!rd.valid && tag_match(bus, rd.tag)) begin
				new_entry.opd[j].valid = 1'b1;
				new_entry.opd[j].data = bus.data;
			end
		end
		if (int_kind && issue_op.use_imm) begin
			new_entry.opd[1].valid = 1'b1;
			new_entry.opd[1].data = DATA_WIDTH'($signed(issue_op.imm)); // Sign extended
		end
	end

endmodule

/* hw/branch_pkg.sv */
package branch_pkg;

	typedef enum logic [1:0] {
		CMP_FZ,
		CMP_FLE,
		CMP_EQ,
		CMP_LE
	} cmp_kind_t;

	localparam int IMM_WIDTH = 16;

	// Decoded branch at issue
	typedef struct packed {
		cmp_kind_t cmp_kind;
		logic use_imm;
		logic signed [IMM_WIDTH-1:0] imm;
	} branch_op_t;

	typedef struct packed {
		cmp_kind_t cmp_kind;
		cpu_pkg::cdb_t [1:0] opd;
	} cmp_entry_t;

	typedef struct packed {
		logic failure; // Holds the prediction until resolved
		logic [cpu_pkg::PATTERN_WIDTH-1:0] pattern;
		logic [cpu_pkg::ADDR_WIDTH-1:0] recovery_addr;
	} branch_entry_t;

	// Integer compares use the GPR file and bus
	function automatic logic is_int_kind(cmp_kind_t kind);
		return kind == CMP_EQ || kind == CMP_LE;
	endfunction

endpackage

/* hw/cpu_pkg.sv */
package cpu_pkg;

	parameter int DATA_WIDTH = 32;
	parameter int TAG_WIDTH = 5;   // Rename tag
	parameter int PATTERN_WIDTH = 8;
	parameter int ADDR_WIDTH = 14; // Instruction address

	// Register read or common data bus broadcast
	typedef struct packed {
		logic valid;
		logic [TAG_WIDTH-1:0] tag;
		logic [DATA_WIDTH-1:0] data;
	} cdb_t;

	// High when the bus broadcasts the given tag
	function automatic logic tag_match(cdb_t bus, logic [TAG_WIDTH-1:0] tag);
		return bus.valid && bus.tag == tag;
	endfunction

endpackage
